/* source/ahb_pkg.sv */
package ahb_pkg;

// ------------------------------------------------------------------------
// Bus widths

localparam int W_ADDR = 32;
localparam int W_DATA = 32;
localparam int W_STRB = W_DATA / 8;             // Byte lanes per word

// ------------------------------------------------------------------------
// AHB-Lite encodings

localparam logic [1:0] HTRANS_IDLE   = 2'b00;
localparam logic [1:0] HTRANS_NSEQ   = 2'b10;
localparam logic [2:0] HSIZE_WORD    = 3'b010;   // Full 32-bit word
localparam logic [3:0] HPROT_DST     = 4'b0011;  // Data, privileged, not cacheable
localparam logic [2:0] HBURST_SINGLE = 3'b000;

// One address phase, same layout on both bus sides
typedef struct packed {
	logic [W_ADDR-1:0] haddr;
	logic              hwrite;
	logic [1:0]        htrans;
	logic [2:0]        hsize;
	logic [3:0]        hprot;
} ahb_req_t;

endpackage

/* source/cache_pkg.sv */
package cache_pkg;

// ------------------------------------------------------------------------
// Geometry and address split

localparam int DEPTH    = 16;                   // Lines, one bus word each
localparam int W_INDEX  = 4;
localparam int W_OFFSET = 2;                    // Byte offset within the word
localparam int W_TAG    = ahb_pkg::W_ADDR - W_INDEX - W_OFFSET;

// Tag entry, one per line
typedef struct packed {
	logic             valid;
	logic             dirty;
	logic [W_TAG-1:0] tag;
} cache_tag_t;

// Controller states
typedef enum logic [4:0] {
	IDLE,                                       // No upstream data phase
	READ_CHECK, READ_CLEAN, READ_FILL, READ_DONE,
	WRITE_CHECK, WRITE_CLEAN, WRITE_FILL, WRITE_MODIFY, WRITE_DONE,
	UWRITE_APH, UWRITE_DPH, UWRITE_DONE,
	UREAD_APH, UREAD_DPH, UREAD_DONE,
	ERR_PH0, ERR_PH1                            // Two-cycle upstream error
} cache_state_t;

// Store write and read strobes
typedef struct packed {
	logic                        t_wen;
	logic                        t_wvalid;
	logic                        t_wdirty;
	logic                        d_ren;
	logic [ahb_pkg::W_STRB-1:0]  d_wen;         // Per byte lane
} store_ctrl_t;

endpackage

/* source/cache_ctrl_fsm.sv */
`timescale 1ns/1ps

module cache_ctrl_fsm import ahb_pkg::*, cache_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         aph_read,          // Upstream read address phase
	input  logic         aph_write,         // Upstream write address phase
	input  logic         aph_cacheable,
	input  logic         hit,
	input  logic         dirty,
	input  logic         dst_hready,
	input  logic         dst_hresp,
	output cache_state_t state,
	output logic [1:0]   dst_htrans,
	output logic         dst_hwrite,
	output logic         src_hready_resp,
	output logic         src_hresp
);

cache_state_t state_nxt;
cache_state_t next_or_idle;                 // Where a new upstream transfer goes
logic         dst_err_ph1;                  // Second cycle of a downstream error
logic         in_check;
logic         miss_aph;

// ------------------------------------------------------------------------
// Next state

always_comb begin
	if (aph_read && !aph_cacheable)
		next_or_idle = UREAD_APH;
	else if (aph_write && !aph_cacheable)
		next_or_idle = UWRITE_APH;
	else if (aph_read)
		next_or_idle = READ_CHECK;
	else if (aph_write)
		next_or_idle = WRITE_CHECK;
	else
		next_or_idle = IDLE;
end

always_comb begin
	state_nxt = state;                      // Hold by default, e.g. dst stall
	case (state)
		IDLE:         state_nxt = next_or_idle;
		READ_CHECK: begin
			if (hit)
				state_nxt = next_or_idle;       // Hit answers this cycle
			else if (dirty)
				state_nxt = READ_CLEAN;
			else
				state_nxt = READ_FILL;
		end
		READ_CLEAN:   if (dst_hready) state_nxt = READ_FILL;
		READ_FILL:    if (dst_hready) state_nxt = READ_DONE;
		READ_DONE:    state_nxt = next_or_idle;
		WRITE_CHECK: begin
			if (hit)
				state_nxt = WRITE_DONE;
			else if (dirty)
				state_nxt = WRITE_CLEAN;
			else
				state_nxt = WRITE_FILL;
		end
		WRITE_CLEAN:  if (dst_hready) state_nxt = WRITE_FILL;
		WRITE_FILL:   if (dst_hready) state_nxt = WRITE_MODIFY;
		WRITE_MODIFY: state_nxt = WRITE_DONE;   // Merge upstream bytes into fresh line
		WRITE_DONE:   state_nxt = next_or_idle;
		UWRITE_APH:   state_nxt = UWRITE_DPH;   // No dst data phase open, so no stall
		UWRITE_DPH:   if (dst_hready) state_nxt = UWRITE_DONE;
		UWRITE_DONE:  state_nxt = next_or_idle;
		UREAD_APH:    state_nxt = UREAD_DPH;
		UREAD_DPH:    if (dst_hready) state_nxt = UREAD_DONE;
		UREAD_DONE:   state_nxt = next_or_idle;
		ERR_PH0:      state_nxt = ERR_PH1;
		ERR_PH1:      state_nxt = next_or_idle;
		default:      state_nxt = IDLE;
	endcase
	// Any completed downstream error ends the transfer
	if (dst_hready && dst_hresp)
		state_nxt = ERR_PH0;
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		state       <= IDLE;
		dst_err_ph1 <= 1'b0;
	end else begin
		state       <= state_nxt;
		dst_err_ph1 <= dst_hresp && !dst_hready;  // Error phase 0 seen on dst
	end
end

// ------------------------------------------------------------------------
// Downstream transfer decode

assign in_check = state == READ_CHECK || state == WRITE_CHECK;
assign miss_aph = in_check && !hit;         // Clean or fill aphase from CHECK

always_comb begin
	if (dst_err_ph1)
		dst_htrans = HTRANS_IDLE;           // Drop the pending aphase after an error
	else if (miss_aph || state == READ_CLEAN || state == WRITE_CLEAN ||
		state == UWRITE_APH || state == UREAD_APH)
		dst_htrans = HTRANS_NSEQ;
	else
		dst_htrans = HTRANS_IDLE;
end

// Write-back of the victim or an uncached write
assign dst_hwrite = (miss_aph && dirty) || state == UWRITE_APH;

// ------------------------------------------------------------------------
// Upstream response

assign src_hready_resp =
	state == IDLE ||
	(state == READ_CHECK && hit) ||
	state == READ_DONE ||
	state == WRITE_DONE ||
	state == UREAD_DONE ||
	state == UWRITE_DONE ||
	state == ERR_PH1;

assign src_hresp = state == ERR_PH0 || state == ERR_PH1;

endmodule

/* source/cache_store.sv */
`timescale 1ns/1ps

module cache_store import ahb_pkg::*, cache_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [W_ADDR-1:0] t_addr,       // Tag port address
	input  logic [W_ADDR-1:0] d_addr,       // Data port address
	input  store_ctrl_t       ctrl,
	input  logic [W_DATA-1:0] wdata,
	output logic              hit,
	output logic              dirty,
	output logic [W_ADDR-1:0] victim_addr,  // Address of the line now held
	output logic [W_DATA-1:0] rdata
);

cache_tag_t              tag_mem [DEPTH];
logic [W_DATA-1:0]       data_mem [DEPTH];

logic [W_INDEX-1:0]      t_index;
logic [W_TAG-1:0]        t_tag;
logic [W_INDEX-1:0]      d_index;

cache_tag_t              rd_entry;          // Registered tag entry
logic [W_TAG-1:0]        rd_tag;            // Tag that was looked up
logic [W_INDEX-1:0]      rd_index;

assign t_index = t_addr[W_OFFSET +: W_INDEX];
assign t_tag   = t_addr[W_ADDR-1 -: W_TAG];
assign d_index = d_addr[W_OFFSET +: W_INDEX];

// ------------------------------------------------------------------------
// Tag array, read whenever it is not written

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		for (int i = 0; i < DEPTH; i++)
			tag_mem[i] <= '0;               // All lines invalid
		rd_entry <= '0;
	end else if (ctrl.t_wen) begin
		tag_mem[t_index] <= '{valid: ctrl.t_wvalid, dirty: ctrl.t_wdirty, tag: t_tag};
	end else begin
		rd_entry <= tag_mem[t_index];
	end
end

always_ff @(posedge clk) begin
	if (!ctrl.t_wen) begin
		rd_tag   <= t_tag;
		rd_index <= t_index;
	end
end

assign hit         = rd_entry.valid && rd_entry.tag == rd_tag;
assign dirty       = rd_entry.valid && rd_entry.dirty;
assign victim_addr = {rd_entry.tag, rd_index, {W_OFFSET{1'b0}}};

// ------------------------------------------------------------------------
// Data array with byte enables

always_ff @(posedge clk) begin
	for (int b = 0; b < W_STRB; b++) begin
		if (ctrl.d_wen[b])
			data_mem[d_index][b*8 +: 8] <= wdata[b*8 +: 8];
	end
	if (ctrl.d_ren)
		rdata <= data_mem[d_index];         // One cycle read latency
end

endmodule

/* source/cache_datapath.sv */
`timescale 1ns/1ps

module cache_datapath import ahb_pkg::*, cache_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  ahb_req_t          src_req,
	input  logic              src_hready,
	input  logic [W_DATA-1:0] src_hwdata,
	input  cache_state_t      state,
	input  logic              hit,
	input  logic              dirty,
	input  logic [W_ADDR-1:0] victim_addr,
	input  logic [W_DATA-1:0] rdata,
	input  logic [W_DATA-1:0] dst_hrdata,
	input  logic              dst_hready,
	input  logic              dst_hresp,
	output logic              aph_read,
	output logic              aph_write,
	output logic              aph_cacheable,
	output logic [W_ADDR-1:0] t_addr,
	output logic [W_ADDR-1:0] d_addr,
	output store_ctrl_t       store_ctrl,
	output logic [W_DATA-1:0] wdata,
	output logic [W_ADDR-1:0] dst_addr,
	output logic [2:0]        dst_hsize,
	output logic [W_DATA-1:0] dst_hwdata,
	output logic [W_DATA-1:0] src_hrdata
);

logic [W_ADDR-1:0] aph_addr;                // Captured upstream address
logic [2:0]        aph_size;
logic [W_ADDR-1:0] fill_addr;
logic [W_STRB-1:0] byte_mask;
logic [W_DATA-1:0] hwdata_q;                // Uncached write data
logic [W_DATA-1:0] hrdata_q;                // Fill or uncached read data
logic              aph_valid;
logic              clean_aph, modify_ph, in_fill, unc_aph;
logic              wen_modify, wen_fill;

// ------------------------------------------------------------------------
// Address phase capture

assign aph_valid     = src_hready && src_req.htrans[1];
assign aph_read      = aph_valid && !src_req.hwrite;
assign aph_write     = aph_valid && src_req.hwrite;
assign aph_cacheable = src_req.hprot[3] && src_req.hprot[2];  // Cacheable, bufferable

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		aph_addr <= '0;
		aph_size <= '0;
	end else if (aph_valid) begin
		aph_addr <= src_req.haddr;
		aph_size <= src_req.hsize;
	end
end

// ------------------------------------------------------------------------
// State decode and store steering

assign clean_aph  = (state == READ_CHECK || state == WRITE_CHECK) && !hit && dirty;
assign modify_ph  = state == WRITE_CHECK || state == WRITE_MODIFY;
assign in_fill    = state == READ_FILL || state == WRITE_FILL;
assign unc_aph    = state == UWRITE_APH || state == UREAD_APH;
assign wen_modify = (state == WRITE_CHECK && hit) || state == WRITE_MODIFY;
assign wen_fill   = dst_hready && in_fill;  // Fill beat completes
assign fill_addr  = {aph_addr[W_ADDR-1:W_OFFSET], {W_OFFSET{1'b0}}};

assign t_addr = (modify_ph || in_fill) ? aph_addr : src_req.haddr;
assign d_addr = clean_aph               ? victim_addr :
                (modify_ph || in_fill)  ? aph_addr    : src_req.haddr;
assign wdata  = modify_ph ? src_hwdata : dst_hrdata;

// Bytes touched by the upstream write
assign byte_mask = W_STRB'((32'd1 << (32'd1 << aph_size)) - 32'd1) << aph_addr[W_OFFSET-1:0];

always_comb begin
	// Tag only changes when a clean hit turns dirty, on modify or on fill
	store_ctrl.t_wen    = (state == WRITE_CHECK && hit && !dirty) ||
	                      state == WRITE_MODIFY || wen_fill;
	store_ctrl.t_wvalid = wen_modify || (wen_fill && !dst_hresp);  // Errored fill stays invalid
	store_ctrl.t_wdirty = wen_modify;
	store_ctrl.d_ren    = aph_read || (clean_aph && dst_hready);   // Victim read for write-back
	store_ctrl.d_wen    = {W_STRB{wen_fill}} | (byte_mask & {W_STRB{wen_modify}});
end

// ------------------------------------------------------------------------
// Downstream request and data

assign dst_addr  = clean_aph ? victim_addr : unc_aph ? aph_addr : fill_addr;
assign dst_hsize = unc_aph ? aph_size : HSIZE_WORD;

always_ff @(posedge clk) begin
	if (state == UWRITE_APH)
		hwdata_q <= src_hwdata;             // Upstream data phase of the uncached write
	if (dst_hready && (state == READ_FILL || state == UREAD_DPH))
		hrdata_q <= dst_hrdata;
end

assign dst_hwdata = state == UWRITE_DPH ? hwdata_q : rdata;
assign src_hrdata = (state == READ_DONE || state == UREAD_DONE) ? hrdata_q : rdata;

endmodule

/* source/ahb_cache_writeback.sv */
`timescale 1ns/1ps

module ahb_cache_writeback import ahb_pkg::*, cache_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	// Upstream AHB-Lite slave
	input  ahb_req_t          src_req,
	input  logic              src_hready,
	input  logic [W_DATA-1:0] src_hwdata,
	output logic              src_hready_resp,
	output logic              src_hresp,
	output logic [W_DATA-1:0] src_hrdata,
	// Downstream AHB-Lite master
	output ahb_req_t          dst_req,
	output logic [2:0]        dst_hburst,
	output logic              dst_hready,
	output logic [W_DATA-1:0] dst_hwdata,
	input  logic              dst_hready_resp,
	input  logic              dst_hresp,
	input  logic [W_DATA-1:0] dst_hrdata
);

cache_state_t      state;
logic              aph_read, aph_write, aph_cacheable;
logic              hit, dirty;
logic [W_ADDR-1:0] victim_addr;
logic [W_ADDR-1:0] t_addr, d_addr, dst_addr;
logic [W_DATA-1:0] store_wdata, store_rdata;
store_ctrl_t       store_ctrl;
logic [1:0]        dst_htrans;
logic              dst_hwrite;
logic [2:0]        dst_hsize;

assign dst_hready = dst_hready_resp;        // Single slave below us

// ------------------------------------------------------------------------
// Downstream request, single word bursts only

assign dst_req    = '{haddr: dst_addr, hwrite: dst_hwrite, htrans: dst_htrans,
                      hsize: dst_hsize, hprot: HPROT_DST};
assign dst_hburst = HBURST_SINGLE;

cache_ctrl_fsm u_fsm (
	.clk, .rst_n,
	.aph_read, .aph_write, .aph_cacheable,
	.hit, .dirty,
	.dst_hready, .dst_hresp,
	.state, .dst_htrans, .dst_hwrite,
	.src_hready_resp, .src_hresp
);

cache_store u_store (
	.clk, .rst_n,
	.t_addr, .d_addr,
	.ctrl  (store_ctrl),
	.wdata (store_wdata),
	.hit, .dirty, .victim_addr,
	.rdata (store_rdata)
);

cache_datapath u_datapath (
	.clk, .rst_n,
	.src_req, .src_hready, .src_hwdata,
	.state, .hit, .dirty, .victim_addr,
	.rdata (store_rdata),
	.dst_hrdata, .dst_hready, .dst_hresp,
	.aph_read, .aph_write, .aph_cacheable,
	.t_addr, .d_addr, .store_ctrl,
	.wdata (store_wdata),
	.dst_addr, .dst_hsize, .dst_hwdata, .src_hrdata
);

endmodule

/* tests/ahb_mem_model.sv */
`timescale 1ns/1ps

module ahb_mem_model import ahb_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  ahb_req_t          req,
	input  logic              hready,         // Bus ready, looped back from this slave
	input  logic [W_DATA-1:0] hwdata,
	output logic              hready_resp,
	output logic              hresp,
	output logic [W_DATA-1:0] hrdata
);

localparam logic [W_ADDR-1:0] ERR_BASE    = 32'hF000_0000;  // Error window start
localparam logic [W_DATA-1:0] DEFAULT_XOR = 32'hA5A5_0000;

logic [W_DATA-1:0] mem [logic [W_ADDR-1:0]];   // Sparse, keyed by word address
logic              active;                     // Data phase open
logic              is_write;
logic              is_err;
logic [W_ADDR-1:0] dph_addr;
logic [2:0]        dph_size;
int unsigned       wait_left;

function automatic logic [W_DATA-1:0] read_word(input logic [W_ADDR-1:0] addr);
	logic [W_ADDR-1:0] key;
	key = {addr[W_ADDR-1:2], 2'b00};
	if (mem.exists(key))
		return mem[key];
	return key ^ DEFAULT_XOR;                 // Never written
endfunction

task automatic write_word(input logic [W_ADDR-1:0] addr, input logic [2:0] size,
	input logic [W_DATA-1:0] data);
	logic [W_STRB-1:0] mask;
	logic [W_DATA-1:0] word;
	mask = W_STRB'(((32'd1 << (32'd1 << size)) - 32'd1) << addr[1:0]);
	word = read_word(addr);
	for (int b = 0; b < W_STRB; b++) begin
		if (mask[b])
			word[b*8 +: 8] = data[b*8 +: 8];  // Only the addressed lanes
	end
	mem[{addr[W_ADDR-1:2], 2'b00}] = word;
endtask

assign hrdata = read_word(dph_addr);

// ------------------------------------------------------------------------
// Response sequencer: waits, then OKAY or two-cycle ERROR

always @(posedge clk or negedge rst_n) begin
	int unsigned w;
	if (!rst_n) begin
		active      <= 1'b0;
		is_write    <= 1'b0;
		is_err      <= 1'b0;
		dph_addr    <= '0;
		dph_size    <= '0;
		wait_left   <= 0;
		hready_resp <= 1'b1;
		hresp       <= 1'b0;
	end else if (hready) begin
		if (active && is_write && !is_err)
			write_word(dph_addr, dph_size, hwdata);  // Data phase ends here
		if (req.htrans[1]) begin
			w = $urandom % 3;                 // 0 to 2 wait states
			active   <= 1'b1;
			is_write <= req.hwrite;
			is_err   <= req.haddr >= ERR_BASE;
			dph_addr <= req.haddr;
			dph_size <= req.hsize;
			if (w != 0) begin
				hready_resp <= 1'b0;
				hresp       <= 1'b0;
				wait_left   <= w - 1;
			end else if (req.haddr >= ERR_BASE) begin
				hready_resp <= 1'b0;          // Error phase 0
				hresp       <= 1'b1;
			end else begin
				hready_resp <= 1'b1;
				hresp       <= 1'b0;
			end
		end else begin
			active      <= 1'b0;
			hready_resp <= 1'b1;
			hresp       <= 1'b0;
		end
	end else if (hresp) begin
		hready_resp <= 1'b1;                  // Error phase 1
	end else if (wait_left != 0) begin
		wait_left <= wait_left - 1;
	end else if (is_err) begin
		hresp <= 1'b1;
	end else begin
		hready_resp <= 1'b1;
	end
end

endmodule

/* tests/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker import ahb_pkg::*; #(
	parameter int NAME_W = 128
) (
	input  logic              clk,
	input  logic              rst_n,
	input  ahb_req_t          src_req,
	input  logic              src_hready,
	input  logic              src_hready_resp,
	input  logic              src_hresp,
	input  logic [W_DATA-1:0] src_hrdata,
	input  ahb_req_t          dst_req,
	input  logic [2:0]        dst_hburst,
	input  logic              exp_load,       // New test issued
	input  logic [NAME_W-1:0] exp_name,
	input  logic              exp_read,
	input  logic [W_DATA-1:0] exp_data,
	input  logic              exp_err,
	output int                pass_cnt,
	output int                fail_cnt
);

typedef struct packed {
	logic [NAME_W-1:0] name;
	logic              is_read;
	logic [W_DATA-1:0] data;
	logic              err;
} expect_t;

expect_t    pending [$];                        // Tests in flight with the oldest in front
logic       in_dph;                             // Upstream data phase open
logic       burst_bad;                          // Non-single dst burst in this test
logic [2:0] burst_seen;

initial begin
	pass_cnt  = 0;
	fail_cnt  = 0;
	burst_bad = 1'b0;
end

task automatic check_one();
	expect_t e;
	logic    ok;
	if (pending.size() == 0) begin
		$display("Upstream transfer completed with no test waiting for it");
		fail_cnt++;
		return;
	end
	e  = pending.pop_front();
	ok = 1'b1;
	if (src_hresp !== e.err) begin
		$display("Fail %0s: expected hresp %0d, actual %0d", e.name, e.err, src_hresp);
		ok = 1'b0;
	end else if (e.is_read && !e.err && src_hrdata !== e.data) begin
		$display("Fail %0s: expected %h, actual %h", e.name, e.data, src_hrdata);
		ok = 1'b0;
	end else if (burst_bad) begin
		$display("Fail %0s: expected hburst %0d, actual %0d", e.name, HBURST_SINGLE,
			burst_seen);
		ok = 1'b0;
	end
	burst_bad = 1'b0;
	if (ok) begin
		$display("Pass %0s", e.name);
		pass_cnt++;
	end else begin
		fail_cnt++;
	end
endtask

// ------------------------------------------------------------------------
// Sample at the edge that ends the data phase

always @(posedge clk) begin
	if (!rst_n) begin
		in_dph    <= 1'b0;
		burst_bad = 1'b0;
	end else begin
		if (exp_load)
			pending.push_back('{name: exp_name, is_read: exp_read, data: exp_data, err: exp_err});
		if (dst_req.htrans[1] && dst_hburst !== HBURST_SINGLE) begin
			burst_bad  = 1'b1;                  // Every dst transfer is a single word
			burst_seen = dst_hburst;
		end
		if (in_dph && src_hready_resp)
			check_one();
		if (src_hready_resp)
			in_dph <= src_hready && src_req.htrans[1];  // Accepted aphase opens next dphase
	end
end

endmodule

/* tests/tb_top.sv */
`timescale 1ns/1ps

module tb_top import ahb_pkg::*;;

localparam int NAME_W  = 128;                   // 16 characters of test name
localparam int TIMEOUT = 200;

logic              clk;
logic              rst_n;
ahb_req_t          src_req;
logic              src_hready;
logic [W_DATA-1:0] src_hwdata;
logic              src_hready_resp, src_hresp;
logic [W_DATA-1:0] src_hrdata;
ahb_req_t          dst_req;
logic [2:0]        dst_hburst;
logic              dst_hready;
logic [W_DATA-1:0] dst_hwdata;
logic              dst_hready_resp, dst_hresp;
logic [W_DATA-1:0] dst_hrdata;
logic              exp_load, exp_read, exp_err;
logic [NAME_W-1:0] exp_name;
logic [W_DATA-1:0] exp_data;
int                pass_cnt, fail_cnt;
int                issued;
logic              run_err;                     // Timeout or bad stimulus

ahb_cache_writeback dut (
	.clk, .rst_n,
	.src_req, .src_hready, .src_hwdata,
	.src_hready_resp, .src_hresp, .src_hrdata,
	.dst_req, .dst_hburst, .dst_hready, .dst_hwdata,
	.dst_hready_resp, .dst_hresp, .dst_hrdata
);

ahb_mem_model u_mem (
	.clk, .rst_n,
	.req (dst_req), .hready (dst_hready), .hwdata (dst_hwdata),
	.hready_resp (dst_hready_resp), .hresp (dst_hresp), .hrdata (dst_hrdata)
);

tb_checker #(.NAME_W(NAME_W)) u_chk (
	.clk, .rst_n,
	.src_req, .src_hready, .src_hready_resp, .src_hresp, .src_hrdata,
	.dst_req, .dst_hburst,
	.exp_load, .exp_name, .exp_read, .exp_data, .exp_err,
	.pass_cnt, .fail_cnt
);

initial begin
	clk = 1'b0;
	forever #4 clk = ~clk;                    // 8 ns period
end

function automatic logic [NAME_W-1:0] pack_name(input string s);
	logic [NAME_W-1:0] v;
	v = '0;
	for (int i = 0; i < s.len() && i < NAME_W / 8; i++)
		v = {v[NAME_W-9:0], s[i]};
	return v;
endfunction

// Loops until the DUT signals ready or TIMEOUT cycles pass
task automatic wait_ready(input string name, output logic ok);
	int cycles;
	cycles = 0;
	do begin
		@(posedge clk);
		cycles++;
	end while (!src_hready_resp && cycles < TIMEOUT);
	ok = src_hready_resp;
	if (!ok)
		$display("Timeout: test %s got no upstream response in %0d cycles", name, TIMEOUT);
endtask

// ------------------------------------------------------------------------
// One upstream transfer with the write data in its data phase

task automatic run_test(input string name, input string op, input logic [W_ADDR-1:0] addr,
	input logic [W_DATA-1:0] wdata, input logic [W_DATA-1:0] rdata, input logic err);
	ahb_req_t req;
	logic     ok;
	req.haddr  = addr;
	req.hwrite = op == "W" || op == "WB" || op == "UW";
	req.htrans = HTRANS_NSEQ;
	req.hsize  = op == "WB" ? 3'b000 : HSIZE_WORD;
	req.hprot  = (op == "UR" || op == "UW") ? 4'b0011 : 4'b1111;  // Bits 3 and 2 cache it
	wait_ready(name, ok);
	if (!ok) begin
		run_err = 1'b1;
		return;
	end
	src_req  <= req;
	exp_load <= 1'b1;
	exp_name <= pack_name(name);
	exp_read <= !req.hwrite;
	exp_data <= rdata;
	exp_err  <= err;
	issued++;
	@(posedge clk);                           // DUT takes the aphase here
	src_req    <= '{haddr: '0, hwrite: 1'b0, htrans: HTRANS_IDLE, hsize: HSIZE_WORD,
	                hprot: 4'b0011};
	exp_load   <= 1'b0;
	src_hwdata <= wdata;
	wait_ready(name, ok);
	if (!ok)
		run_err = 1'b1;
endtask

initial begin
	int                fd;
	string             line, name, op;
	logic [W_ADDR-1:0] addr;
	logic [W_DATA-1:0] wdata, rdata;
	int                err;
	void'($urandom(32'h3006));
	rst_n      = 1'b0;
	src_req    = '{haddr: '0, hwrite: 1'b0, htrans: HTRANS_IDLE, hsize: HSIZE_WORD,
	               hprot: 4'b0011};
	src_hready = 1'b1;                        // Held high with the DUT as the only slave
	src_hwdata = '0;
	exp_load   = 1'b0;
	exp_name   = '0;
	exp_read   = 1'b0;
	exp_data   = '0;
	exp_err    = 1'b0;
	issued     = 0;
	run_err    = 1'b0;
	repeat (16) @(posedge clk);
	rst_n <= 1'b1;
	fd = $fopen("tests/cache_stim.txt", "r");
	if (fd == 0) begin
		$display("Cannot open the stimulus file tests/cache_stim.txt");
		run_err = 1'b1;
	end else begin
		while (!$feof(fd) && !run_err) begin
			if ($fgets(line, fd) == 0)
				continue;
			if (line.len() < 2 || line[0] == 8'h23)  // Blank or comment line
				continue;
			if ($sscanf(line, "%s %s %h %h %h %d", name, op, addr, wdata, rdata, err) != 6) begin
				$display("Malformed stimulus line: %s", line);
				run_err = 1'b1;
			end else begin
				run_test(name, op, addr, wdata, rdata, err != 0);
			end
		end
		$fclose(fd);
	end
	repeat (2) @(posedge clk);                // Let the last check settle
	$display("Tests issued %0d, passed %0d, failed %0d", issued, pass_cnt, fail_cnt);
	if (pass_cnt + fail_cnt != issued)
		$display("Some issued tests were never checked");
	if (!run_err && issued != 0 && fail_cnt == 0 && pass_cnt == issued)
		$display("NO ERRORS");
	else
		$display("ERRORS FOUND");
	$finish;
end

endmodule

/* tests/cache_stim.txt */
# name op addr wdata expected_rdata expected_err
# op: R cached read, W cached word write, WB cached byte write, UR/UW uncached
cold_rd      R  00000100 00000000 A5A50100 0
warm_rd      R  00000100 00000000 A5A50100 0
wr_word      W  00000204 12345678 00000000 0
rd_word      R  00000204 00000000 12345678 0
wr_byte_hit  WB 00000205 0000AB00 00000000 0
rd_merge     R  00000204 00000000 1234AB78 0
wr_byte_miss WB 0000031A 00CD0000 00000000 0
rd_byte_miss R  00000318 00000000 A5CD0318 0
ev_wr        W  00001008 CAFEF00D 00000000 0
ev_rd        R  00002008 00000000 A5A52008 0
ev_chk       UR 00001008 00000000 CAFEF00D 0
unc_wr       UW 00003010 0BADBEEF 00000000 0
unc_rd       UR 00003010 00000000 0BADBEEF 0
clean_rd     R  00004014 00000000 A5A54014 0
err_unc_rd   UR F0000000 00000000 00000000 1
err_cached   R  F0000010 00000000 00000000 1
after_err    R  00000010 00000000 A5A50010 0
err_wr       W  F0000020 11111111 00000000 1
after_err_wr R  00000020 00000000 A5A50020 0
err_unc_wr   UW F0000030 22222222 00000000 1

/* compile.f */
source/ahb_pkg.sv
source/cache_pkg.sv
source/cache_ctrl_fsm.sv
source/cache_store.sv
source/cache_datapath.sv
source/ahb_cache_writeback.sv
tests/ahb_mem_model.sv
tests/tb_checker.sv
tests/tb_top.sv

/* Bender.yml */
package:
  name: ahb_cache_writeback

sources:
  - files:
      - source/ahb_pkg.sv
      - source/cache_pkg.sv
      - source/cache_ctrl_fsm.sv
      - source/cache_store.sv
      - source/cache_datapath.sv
      - source/ahb_cache_writeback.sv
  - target: test
    files:
      - tests/ahb_mem_model.sv
      - tests/tb_checker.sv
      - tests/tb_top.sv
